/* hdl/backplane_pkg.sv */
//******************************
// common widths, types, i/o page map and vector tables
// shared by every backplane block and the testbench
//******************************
`default_nettype none

package backplane_pkg;

   //******************************
   // bus widths
   //******************************
   localparam int ADR_W    = 22;           // full 22-bit bus address
   localparam int DATA_W   = 16;           // bus word
   localparam int IOPAGE_W = 16;           // low address bits seen by the i/o page

   typedef logic [ADR_W-1:0]  adr_t;
   typedef logic [DATA_W-1:0] data_t;

   //******************************
   // i/o page devices
   //******************************
   localparam int NUM_IODEV = 10;

   localparam int UART1 = 0;               // console serial port
   localparam int UART2 = 1;               // second serial port
   localparam int LPT   = 2;               // printer
   localparam int RK11  = 3;               // rk disk
   localparam int RK611 = 4;               // dm disk
   localparam int DW    = 5;               // winchester
   localparam int RX    = 6;               // dx floppy
   localparam int MY    = 7;               // my floppy
   localparam int RH70  = 8;               // db disk
   localparam int KGD   = 9;               // graphics

   typedef logic [NUM_IODEV-1:0][DATA_W-1:0] iodev_data_t;   // read buses, word i per device

   // register block base per device, octal
   localparam logic [IOPAGE_W-1:0] IODEV_BASE [NUM_IODEV] = '{
      16'o177560,                          // uart1 177560 to 177566
      16'o176500,                          // uart2 176500 to 176506
      16'o177514,                          // lpt 177514 to 177516
      16'o177400,                          // rk 177400 to 177416
      16'o177440,                          // dm 177440 to 177476
      16'o174000,                          // dw 174000 to 174036
      16'o177170,                          // dx 177170 to 177172
      16'o172140,                          // my 172140 to 172142
      16'o176700,                          // db 176700 to 176776
      16'o176640                           // kgd 176640 to 176646
   };

   // low address bits ignored by the compare
   localparam int IODEV_SPAN [NUM_IODEV] = '{3, 3, 2, 4, 5, 5, 2, 2, 6, 3};

   //******************************
   // vectored interrupts
   //******************************
   localparam int VEC_W = 9;               // vector bus to the cpu
   typedef logic [VEC_W-1:0] vec_t;

   localparam int BR4_N = 5;
   // uart1 tx, uart1 rx, uart2 tx, uart2 rx, lpt
   localparam data_t BR4_VECTORS [BR4_N] = '{16'o064, 16'o060, 16'o334, 16'o330, 16'o200};

   localparam int BR5_N = 6;
   // dx, dw, rk, db, dm, my
   localparam data_t BR5_VECTORS [BR5_N] = '{16'o264, 16'o300, 16'o220, 16'o254, 16'o210,
                                             16'o170};

   //******************************
   // sd-card sharing
   //******************************
   localparam int NUM_SDCTL  = 6;          // rk, dw, dm, db, dx, my in priority order
   localparam int SDREQ_SYNC = 2;          // request synchronizer stages

   typedef struct packed {
      logic cs;                            // card select, active low
      logic mosi;
      logic sclk;
   } spi_lines_t;

   typedef spi_lines_t [NUM_SDCTL-1:0] spi_bus_t;

   // card lines with no controller granted
   localparam spi_lines_t SPI_IDLE = '{cs: 1'b1, mosi: 1'b1, sclk: 1'b0};

endpackage

`default_nettype wire

/* hdl/iopage_decoder.sv */
//******************************
// i/o page address decode, acknowledge merge and read-data
// return mux; purely combinational, sits between bus master and devices
//******************************
`timescale 1ns/100ps
`default_nettype none

module iopage_decoder (
   input  wire                           bus_stb_i,    // i/o page cycle strobe
   input  wire backplane_pkg::adr_t      adr_i,        // bus address
   input  wire                           ram_stb_i,    // memory cycle strobe
   input  wire                           ram_ack_i,    // memory acknowledge
   input  wire backplane_pkg::data_t     ram_rdata_i,  // memory read data
   input  wire [backplane_pkg::NUM_IODEV-1:0] dev_ack_i,  // device acknowledges
   input  wire backplane_pkg::iodev_data_t    dev_rdata_i, // device read buses
   output logic [backplane_pkg::NUM_IODEV-1:0] dev_stb_o, // device select strobes
   output logic                          ack_o,        // merged acknowledge
   output backplane_pkg::data_t          rdata_o       // data back to the master
);

   logic [backplane_pkg::IOPAGE_W-1:0] adr_lo;          // i/o page offset bits

   assign adr_lo = adr_i[backplane_pkg::IOPAGE_W-1:0];  // upper bits not decoded

   //******************************
   // device strobes
   //******************************
   // each device owns an aligned block; the low IODEV_SPAN bits
   // select its registers and are masked out of the compare
   for (genvar i = 0; i < backplane_pkg::NUM_IODEV; i++) begin : g_dev
      localparam logic [backplane_pkg::IOPAGE_W-1:0] MASK =
         {backplane_pkg::IOPAGE_W{1'b1}} << backplane_pkg::IODEV_SPAN[i];  // kept bits
      localparam logic [backplane_pkg::IOPAGE_W-1:0] BASE =
         backplane_pkg::IODEV_BASE[i] & MASK;                               // aligned base

      logic hit;                                         // address inside block

      assign hit          = (adr_lo & MASK) == BASE;
      assign dev_stb_o[i] = bus_stb_i & hit;             // qualified by cycle strobe
   end

   //******************************
   // acknowledge merge
   //******************************
   // any responder ends the cycle
   assign ack_o = ram_ack_i | (|dev_ack_i);

   //******************************
   // read-data mux
   //******************************
   // gated OR; unselected sources contribute zero so a
   // single selected source comes through untouched
   always_comb begin
      rdata_o = ram_stb_i ? ram_rdata_i : '0;            // memory path
      for (int i = 0; i < backplane_pkg::NUM_IODEV; i++) begin
         if (dev_stb_o[i]) begin
            rdata_o = rdata_o | dev_rdata_i[i];          // device word i
         end
      end
   end

endmodule

`default_nettype wire

/* hdl/vector_irq_ctrl.sv */
//******************************
// one priority level of vectored interrupts; index 0 wins,
// vector handed out on cpu strobe, instantiated per bus request level
//******************************
`timescale 1ns/100ps
`default_nettype none

module vector_irq_ctrl #(
   parameter int N = 5,                                      // source count
   parameter backplane_pkg::data_t VEC_TABLE [N] = '{default: '0}  // vector per source
) (
   input  wire                 sdclock,
   input  wire                 arst_n_i,
   input  wire [N-1:0]         ireq_i,      // level requests from devices
   input  wire                 istb_i,      // cpu asks for a vector
   output logic [N-1:0]        iack_o,      // one-cycle ack to the winner
   output logic                irq_o,       // request to the cpu
   output logic                ack_o,       // vector valid
   output backplane_pkg::vec_t vector_o     // zero while idle
);

   logic [N-1:0]        pick;               // one-hot highest pending
   backplane_pkg::vec_t pick_vec;           // its vector
   logic                irq_q;
   logic                ack_q;
   logic [N-1:0]        iack_q;
   backplane_pkg::vec_t vec_q;

   //******************************
   // fixed priority pick
   //******************************
   always_comb begin
      pick     = '0;
      pick_vec = '0;
      for (int i = N - 1; i >= 0; i--) begin   // lowest index overrides
         if (ireq_i[i]) begin
            pick     = '0;
            pick[i]  = 1'b1;
            pick_vec = VEC_TABLE[i][backplane_pkg::VEC_W-1:0];  // truncated to bus
         end
      end
   end

   //******************************
   // request and vector state
   //******************************
   always_ff @(posedge sdclock or negedge arst_n_i) begin
      if (!arst_n_i) begin
         irq_q  <= 1'b0;
         ack_q  <= 1'b0;
         iack_q <= '0;
         vec_q  <= '0;
      end else begin
         irq_q  <= |ireq_i;                    // pending summary
         iack_q <= '0;                         // pulse lasts one cycle
         if (!ack_q) begin
            if (istb_i && (|ireq_i)) begin     // strobe with something pending
               ack_q  <= 1'b1;
               iack_q <= pick;
               vec_q  <= pick_vec;
            end
         end else if (!istb_i) begin           // cpu done with the vector
            ack_q <= 1'b0;
            vec_q <= '0;
         end
      end
   end

   assign irq_o    = irq_q;
   assign ack_o    = ack_q;
   assign iack_o   = iack_q;
   assign vector_o = vec_q;                    // cleared with ack, so merge by OR

endmodule

`default_nettype wire

/* hdl/sdcard_arbiter.sv */
//******************************
// sd-card sharing among the disk controllers; synchronized
// requests, non-preemptive priority grant and spi line routing
//******************************
`timescale 1ns/100ps
`default_nettype none

module sdcard_arbiter (
   input  wire                               sdclock,
   input  wire                               arst_n_i,
   input  wire [backplane_pkg::NUM_SDCTL-1:0] sdreq_i,    // card wanted, per controller
   input  wire backplane_pkg::spi_bus_t      ctl_spi_i,  // spi lines from each controller
   output logic [backplane_pkg::NUM_SDCTL-1:0] sdack_o,  // one-hot card grant
   output backplane_pkg::spi_lines_t         sdcard_o    // lines to the card
);

   localparam int NCTL  = backplane_pkg::NUM_SDCTL;
   localparam int NSYNC = backplane_pkg::SDREQ_SYNC;

   logic [NSYNC-1:0][NCTL-1:0] sync_q;          // request synchronizer chain
   logic [NCTL-1:0]            req_s;           // synchronized requests
   logic [NCTL-1:0]            pick;            // one-hot highest request
   logic [NCTL-1:0]            grant_q;         // current owner
   logic                       idle;            // nobody owns the card
   logic                       done;            // owner dropped its request

   //******************************
   // request synchronizer
   //******************************
   // controllers may run their own state machines, so every
   // request gets the same two flops, rk included
   always_ff @(posedge sdclock or negedge arst_n_i) begin
      if (!arst_n_i) begin
         sync_q <= '0;
      end else begin
         sync_q <= {sync_q[NSYNC-2:0], sdreq_i};   // stage 0 takes the raw level
      end
   end

   assign req_s = sync_q[NSYNC-1];

   //******************************
   // priority pick
   //******************************
   always_comb begin
      pick = '0;
      for (int i = NCTL - 1; i >= 0; i--) begin   // index 0 is rk, highest
         if (req_s[i]) begin
            pick    = '0;
            pick[i] = 1'b1;
         end
      end
   end

   assign idle = grant_q == '0;
   assign done = (grant_q & ~req_s) != '0;        // owner request gone

   //******************************
   // grant register
   //******************************
   // no preemption; after a release the register sits at zero
   // for one cycle before the next pick is taken
   always_ff @(posedge sdclock or negedge arst_n_i) begin
      if (!arst_n_i) begin
         grant_q <= '0;
      end else if (idle) begin
         grant_q <= pick;                         // may stay zero
      end else if (done) begin
         grant_q <= '0;                           // free the card
      end
   end

   assign sdack_o = grant_q;

   //******************************
   // spi line mux
   //******************************
   always_comb begin
      sdcard_o = backplane_pkg::SPI_IDLE;         // card deselected
      for (int i = 0; i < NCTL; i++) begin
         if (grant_q[i]) begin
            sdcard_o = ctl_spi_i[i];              // owner drives the card
         end
      end
   end

endmodule

`default_nettype wire

/* hdl/backplane_top.sv */
//******************************
// backplane glue core; i/o page decode, two vectored interrupt
// levels and the shared sd-card arbiter on one clock
//******************************
`timescale 1ns/100ps
`default_nettype none

module backplane_top (
   input  wire                                sdclock,
   input  wire                                arst_n_i,
   // bus side
   input  wire                                bus_stb_i,    // i/o page cycle
   input  wire backplane_pkg::adr_t           adr_i,
   input  wire                                ram_stb_i,    // memory cycle
   input  wire                                ram_ack_i,
   input  wire backplane_pkg::data_t          ram_rdata_i,
   input  wire [backplane_pkg::NUM_IODEV-1:0] dev_ack_i,
   input  wire backplane_pkg::iodev_data_t    dev_rdata_i,
   output logic [backplane_pkg::NUM_IODEV-1:0] dev_stb_o,
   output logic                               ack_o,        // memory or device done
   output backplane_pkg::data_t               rdata_o,
   // interrupts
   input  wire [backplane_pkg::BR4_N-1:0]     br4_ireq_i,   // priority 4 sources
   input  wire [backplane_pkg::BR5_N-1:0]     br5_ireq_i,   // priority 5 sources
   input  wire [1:0]                          istb_i,       // bit 0 level 4, bit 1 level 5
   output logic [backplane_pkg::BR4_N-1:0]    br4_iack_o,
   output logic [backplane_pkg::BR5_N-1:0]    br5_iack_o,
   output logic [1:0]                         irq_o,        // bit 0 level 4, bit 1 level 5
   output logic                               iack_o,       // vector valid to cpu
   output backplane_pkg::vec_t                vector_o,
   // sd card
   input  wire [backplane_pkg::NUM_SDCTL-1:0] sdreq_i,
   input  wire backplane_pkg::spi_bus_t       ctl_spi_i,
   output logic [backplane_pkg::NUM_SDCTL-1:0] sdack_o,
   output backplane_pkg::spi_lines_t          sdcard_o,
   output logic [backplane_pkg::NUM_SDCTL-1:0] sd_led_n_o   // lit while asking
);

   backplane_pkg::vec_t vec4, vec5;          // per-level vectors
   logic                ack4, ack5;          // per-level vector valid

   //******************************
   // i/o page
   //******************************
   iopage_decoder u_decoder (
      .bus_stb_i  (bus_stb_i),
      .adr_i      (adr_i),
      .ram_stb_i  (ram_stb_i),
      .ram_ack_i  (ram_ack_i),
      .ram_rdata_i(ram_rdata_i),
      .dev_ack_i  (dev_ack_i),
      .dev_rdata_i(dev_rdata_i),
      .dev_stb_o  (dev_stb_o),
      .ack_o      (ack_o),
      .rdata_o    (rdata_o)
   );

   //******************************
   // interrupt levels
   //******************************
   vector_irq_ctrl #(
      .N        (backplane_pkg::BR4_N),
      .VEC_TABLE(backplane_pkg::BR4_VECTORS)
   ) vic4 (
      .sdclock (sdclock),
      .arst_n_i(arst_n_i),
      .ireq_i  (br4_ireq_i),
      .istb_i  (istb_i[0]),
      .iack_o  (br4_iack_o),
      .irq_o   (irq_o[0]),
      .ack_o   (ack4),
      .vector_o(vec4)
   );

   vector_irq_ctrl #(
      .N        (backplane_pkg::BR5_N),
      .VEC_TABLE(backplane_pkg::BR5_VECTORS)
   ) vic5 (
      .sdclock (sdclock),
      .arst_n_i(arst_n_i),
      .ireq_i  (br5_ireq_i),
      .istb_i  (istb_i[1]),
      .iack_o  (br5_iack_o),
      .irq_o   (irq_o[1]),
      .ack_o   (ack5),
      .vector_o(vec5)
   );

   assign vector_o = vec4 | vec5;            // idle level drives zero
   assign iack_o   = ack4 | ack5;

   //******************************
   // sd card
   //******************************
   sdcard_arbiter u_sd_arb (
      .sdclock  (sdclock),
      .arst_n_i (arst_n_i),
      .sdreq_i  (sdreq_i),
      .ctl_spi_i(ctl_spi_i),
      .sdack_o  (sdack_o),
      .sdcard_o (sdcard_o)
   );

   assign sd_led_n_o = ~sdreq_i;             // raw requests, active-low leds

endmodule

`default_nettype wire

/* sim/backplane_tb.sv */
//******************************
// testbench for the backplane core; decoder, both interrupt levels
// and the sd arbiter checked against reference functions
//******************************
`timescale 1ns/100ps
`default_nettype none

module backplane_tb;

   localparam int NDEV = backplane_pkg::NUM_IODEV;
   localparam int NCTL = backplane_pkg::NUM_SDCTL;

   typedef struct packed {
      logic [NDEV-1:0]      stb;          // expected device strobes
      logic                 ack;
      backplane_pkg::data_t rdata;
   } dec_exp_t;

   typedef struct packed {
      logic                valid;         // something pending
      logic [5:0]          win;           // one-hot winner sized for the widest level
      backplane_pkg::vec_t vec;
   } irq_exp_t;

   logic                              sdclock = 1'b0;
   logic                              arst_n_i;
   logic                              bus_stb_i;
   backplane_pkg::adr_t               adr_i;
   logic                              ram_stb_i;
   logic                              ram_ack_i;
   backplane_pkg::data_t              ram_rdata_i;
   logic [NDEV-1:0]                   dev_ack_i;
   backplane_pkg::iodev_data_t        dev_rdata_i;
   logic [backplane_pkg::BR4_N-1:0]   br4_ireq_i;
   logic [backplane_pkg::BR5_N-1:0]   br5_ireq_i;
   logic [1:0]                        istb_i;
   logic [NCTL-1:0]                   sdreq_i;
   backplane_pkg::spi_bus_t           ctl_spi_i;
   wire [NDEV-1:0]                    dev_stb_o;
   wire                               ack_o;
   wire backplane_pkg::data_t         rdata_o;
   wire [backplane_pkg::BR4_N-1:0]    br4_iack_o;
   wire [backplane_pkg::BR5_N-1:0]    br5_iack_o;
   wire [1:0]                         irq_o;
   wire                               iack_o;
   wire backplane_pkg::vec_t          vector_o;
   wire [NCTL-1:0]                    sdack_o;
   wire backplane_pkg::spi_lines_t    sdcard_o;
   wire [NCTL-1:0]                    sd_led_n_o;

   integer          seed;
   int              err_count   = 0;
   int              check_count = 0;
   logic            check_en;
   logic [NCTL-1:0] exp_grant;            // card owner the arbiter should show

   backplane_top DUT (.*);

   always #20 sdclock = ~sdclock;         // 40 ns period

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      check_count++;
      if (got !== exp) begin
         err_count++;
         $display("ERROR at %0d ns: %s is %0h, expected %0h", $time, name, got, exp);
      end
   endtask

   //******************************
   // reference functions
   //******************************
   function automatic dec_exp_t decode_expect(input logic stb, input backplane_pkg::adr_t adr,
         input logic rstb, input logic rack, input backplane_pkg::data_t rdata,
         input logic [NDEV-1:0] acks, input backplane_pkg::iodev_data_t data);
      dec_exp_t e;
      e.stb   = '0;
      e.ack   = rack | (|acks);
      e.rdata = rstb ? rdata : '0;
      for (int i = 0; i < NDEV; i++) begin
         // same block when the bits above the span agree
         if (stb && (adr[15:0] >> backplane_pkg::IODEV_SPAN[i]) ==
                    (backplane_pkg::IODEV_BASE[i] >> backplane_pkg::IODEV_SPAN[i])) begin
            e.stb[i] = 1'b1;
            e.rdata  = e.rdata | data[i];
         end
      end
      return e;
   endfunction

   function automatic irq_exp_t irq_expect(input int lvl, input logic [5:0] req);
      irq_exp_t e;
      e       = '0;
      e.valid = |req;
      e.win   = req & (~req + 6'd1);      // lowest set index wins
      if (lvl == 0) begin
         for (int i = 0; i < backplane_pkg::BR4_N; i++) begin
            if (e.win[i]) e.vec = backplane_pkg::BR4_VECTORS[i][backplane_pkg::VEC_W-1:0];
         end
      end else begin
         for (int i = 0; i < backplane_pkg::BR5_N; i++) begin
            if (e.win[i]) e.vec = backplane_pkg::BR5_VECTORS[i][backplane_pkg::VEC_W-1:0];
         end
      end
      return e;
   endfunction

   function automatic logic [NCTL-1:0] highest_request(input logic [NCTL-1:0] req);
      return req & (~req + 6'd1);         // rk side first
   endfunction

   function automatic backplane_pkg::spi_lines_t card_expect(input logic [NCTL-1:0] grant,
                                                             input backplane_pkg::spi_bus_t spi);
      backplane_pkg::spi_lines_t l;
      l = backplane_pkg::SPI_IDLE;
      for (int i = 0; i < NCTL; i++) begin
         if (grant[i]) l = spi[i];
      end
      return l;
   endfunction

   function automatic logic [5:0] level_iack(input int lvl);
      if (lvl == 0) return {1'b0, br4_iack_o};
      return br5_iack_o;
   endfunction

   //******************************
   // per-cycle compare
   //******************************
   // sampled mid low phase once inputs and registers settle
   always @(negedge sdclock) begin : compare
      dec_exp_t        d;
      logic [NCTL-1:0] led_exp;
      #10;
      if (check_en) begin
         d       = decode_expect(bus_stb_i, adr_i, ram_stb_i, ram_ack_i, ram_rdata_i,
                                 dev_ack_i, dev_rdata_i);
         led_exp = ~sdreq_i;
         check_value("dev_stb_o", 32'(dev_stb_o), 32'(d.stb));
         check_value("ack_o", 32'(ack_o), 32'(d.ack));
         check_value("rdata_o", 32'(rdata_o), 32'(d.rdata));
         check_value("sd_led_n_o", 32'(sd_led_n_o), 32'(led_exp));
         check_value("sdack_o", 32'(sdack_o), 32'(exp_grant));
         check_value("sdcard_o", 32'(sdcard_o), 32'(card_expect(exp_grant, ctl_spi_i)));
      end
   end

   //******************************
   // stimulus helpers
   //******************************
   task automatic next_cycle();
      logic [31:0] rnd;
      @(negedge sdclock);
      rnd       = $random(seed);
      ctl_spi_i = rnd[3*NCTL-1:0];        // fresh spi lines every cycle
   endtask

   task automatic drive_bus(input logic stb, input logic [15:0] lo);
      logic [31:0] rnd;
      next_cycle();
      rnd         = $random(seed);
      bus_stb_i   = stb;
      adr_i       = {rnd[5:0], lo};       // upper bits not decoded
      ram_stb_i   = rnd[6];
      ram_ack_i   = rnd[7] & rnd[8];
      ram_rdata_i = rnd[31:16];
      rnd         = $random(seed);
      dev_ack_i   = rnd[9:0] & rnd[19:10] & rnd[29:20];   // sparse acks
      for (int i = 0; i < NDEV; i++) begin
         rnd            = $random(seed);
         dev_rdata_i[i] = rnd[15:0];
      end
   endtask

   task automatic wait_irq(input logic [1:0] want, input int lat);
      int n;
      n = 0;
      while (irq_o !== want && n < 20) begin
         next_cycle();
         n++;
      end
      if (irq_o !== want) begin
         err_count++;
         $display("timeout: irq_o never reached %b", want);
      end else begin
         check_value("irq_o latency", 32'(n), 32'(lat));
      end
   endtask

   task automatic wait_grant(input logic [NCTL-1:0] want, input int lat);
      int n;
      n = 0;
      while (sdack_o !== want && n < 20) begin
         next_cycle();
         n++;
      end
      if (sdack_o !== want) begin
         err_count++;
         $display("timeout: sd card grant never reached %b", want);
      end else begin
         check_value("sdack_o latency", 32'(n), 32'(lat));
      end
      exp_grant = want;
   endtask

   task automatic release_grants();
      logic [NCTL-1:0] nxt;
      while (exp_grant != '0) begin
         sdreq_i = sdreq_i & ~exp_grant;  // owner finished
         wait_grant('0, 3);
         nxt = highest_request(sdreq_i);
         if (nxt != '0) wait_grant(nxt, 1);   // one idle cycle first
      end
   endtask

   task automatic irq_trial(input int lvl, input logic [5:0] req);
      irq_exp_t e;
      string    name;
      e    = irq_expect(lvl, req);
      name = (lvl == 0) ? "br4_iack_o" : "br5_iack_o";
      next_cycle();
      if (lvl == 0) br4_ireq_i = req[4:0];
      else br5_ireq_i = req;
      next_cycle();
      check_value("irq_o", 32'(irq_o[lvl]), 32'(e.valid));
      istb_i[lvl] = 1'b1;
      next_cycle();
      check_value("iack_o", 32'(iack_o), 32'(e.valid));
      check_value("vector_o", 32'(vector_o), 32'(e.vec));
      check_value(name, 32'(level_iack(lvl)), 32'(e.win));
      next_cycle();                       // strobe still high
      check_value(name, 32'(level_iack(lvl)), 32'd0);
      check_value("iack_o", 32'(iack_o), 32'(e.valid));
      check_value("vector_o", 32'(vector_o), 32'(e.vec));
      istb_i[lvl] = 1'b0;
      next_cycle();
      check_value("iack_o", 32'(iack_o), 32'd0);
      check_value("vector_o", 32'(vector_o), 32'd0);
      br4_ireq_i = '0;
      br5_ireq_i = '0;
      next_cycle();
      check_value("irq_o", 32'(irq_o[lvl]), 32'd0);
   endtask

   task automatic two_level_trial();
      logic [31:0] rnd;
      irq_exp_t    e4;
      irq_exp_t    e5;
      rnd = $random(seed);
      e4  = irq_expect(0, {1'b0, rnd[4:0] | 5'b10000});   // both levels pending
      e5  = irq_expect(1, rnd[13:8] | 6'b100000);
      next_cycle();
      br4_ireq_i = rnd[4:0] | 5'b10000;
      br5_ireq_i = rnd[13:8] | 6'b100000;
      wait_irq(2'b11, 1);
      istb_i = 2'b01;
      next_cycle();
      check_value("vector_o", 32'(vector_o), 32'(e4.vec));
      check_value("iack_o", 32'(iack_o), 32'd1);
      check_value("br4_iack_o", 32'(br4_iack_o), 32'(e4.win));
      check_value("br5_iack_o", 32'(br5_iack_o), 32'd0);
      istb_i = 2'b00;
      next_cycle();
      check_value("iack_o", 32'(iack_o), 32'd0);
      istb_i = 2'b10;
      next_cycle();
      check_value("vector_o", 32'(vector_o), 32'(e5.vec));
      check_value("iack_o", 32'(iack_o), 32'd1);
      check_value("br5_iack_o", 32'(br5_iack_o), 32'(e5.win));
      check_value("br4_iack_o", 32'(br4_iack_o), 32'd0);
      istb_i = 2'b00;
      next_cycle();
      check_value("iack_o", 32'(iack_o), 32'd0);
      check_value("vector_o", 32'(vector_o), 32'd0);
      br4_ireq_i = '0;
      br5_ireq_i = '0;
      wait_irq(2'b00, 1);
   endtask

   //******************************
   // test sequence
   //******************************
   initial begin : stimulus
      logic [31:0] rnd;
      logic [15:0] lo;
      logic [15:0] sz;
      logic [15:0] off;
      logic [5:0]  req;
      int          k;
      seed        = 32'h6fa5_2990;
      arst_n_i    = 1'b0;
      bus_stb_i   = 1'b0;
      adr_i       = '0;
      ram_stb_i   = 1'b0;
      ram_ack_i   = 1'b0;
      ram_rdata_i = '0;
      dev_ack_i   = '0;
      dev_rdata_i = '0;
      br4_ireq_i  = '0;
      br5_ireq_i  = '0;
      istb_i      = '0;
      sdreq_i     = '0;
      ctl_spi_i   = '0;
      exp_grant   = '0;
      check_en    = 1'b0;
      repeat (5) @(negedge sdclock);      // reset held 5 cycles
      check_value("irq_o", 32'(irq_o), 32'd0);
      check_value("iack_o", 32'(iack_o), 32'd0);
      check_value("br4_iack_o", 32'(br4_iack_o), 32'd0);
      check_value("br5_iack_o", 32'(br5_iack_o), 32'd0);
      check_value("vector_o", 32'(vector_o), 32'd0);
      check_value("sdack_o", 32'(sdack_o), 32'd0);
      check_value("sdcard_o", 32'(sdcard_o), 32'(backplane_pkg::SPI_IDLE));
      arst_n_i = 1'b1;
      check_en = 1'b1;

      // block edges per device and random traffic
      for (int i = 0; i < NDEV; i++) begin
         lo = backplane_pkg::IODEV_BASE[i];
         sz = 16'd1 << backplane_pkg::IODEV_SPAN[i];
         drive_bus(1'b1, lo);
         drive_bus(1'b1, lo + sz - 16'd1);   // last register
         drive_bus(1'b1, lo + sz);           // one past the block
      end
      repeat (200) begin
         rnd = $random(seed);
         k   = int'(rnd[11:8]) % NDEV;
         off = {9'd0, rnd[22:16]} & ((16'd2 << backplane_pkg::IODEV_SPAN[k]) - 16'd1);
         lo  = rnd[0] ? backplane_pkg::IODEV_BASE[k] + off : rnd[31:16];
         drive_bus(rnd[2] | rnd[3], lo);
      end
      drive_bus(1'b0, 16'd0);

      irq_trial(0, 6'd0);                 // strobe with nothing pending
      irq_trial(1, 6'd0);
      repeat (16) begin
         rnd = $random(seed);
         irq_trial(0, {1'b0, rnd[4:0]});
         irq_trial(1, rnd[13:8]);
      end
      repeat (6) two_level_trial();

      // dm and dx ask while a late rk request must wait
      next_cycle();
      sdreq_i = 6'b010100;
      wait_grant(6'b000100, 3);
      sdreq_i[0] = 1'b1;
      repeat (6) begin
         next_cycle();
         check_value("sdack_o", 32'(sdack_o), 32'(6'b000100));
      end
      release_grants();
      repeat (8) begin
         rnd = $random(seed);
         req = (rnd[5:0] == 6'd0) ? 6'b100000 : rnd[5:0];
         next_cycle();
         sdreq_i = req;
         wait_grant(highest_request(req), 3);
         repeat (4) next_cycle();         // card traffic
         release_grants();
      end

      // every controller owns the card once
      for (int i = 0; i < NCTL; i++) begin
         next_cycle();
         sdreq_i    = '0;
         sdreq_i[i] = 1'b1;
         wait_grant(sdreq_i, 3);
         repeat (4) next_cycle();         // card traffic
         release_grants();
      end

      next_cycle();
      $display("checks %0d, errors %0d", check_count, err_count);
      if (err_count == 0) begin
         $display("TEST OK");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* filelist.f */
hdl/backplane_pkg.sv
hdl/iopage_decoder.sv
hdl/vector_irq_ctrl.sv
hdl/sdcard_arbiter.sv
hdl/backplane_top.sv
sim/backplane_tb.sv

/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary -j 0
TOP       := backplane_tb
FILELIST  := filelist.f

OBJDIR    := obj_dir
SIM       := $(OBJDIR)/V$(TOP)
SRCS      := $(shell grep -v '^+' $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

# pass only when the pass line shows up in the output
run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "TEST OK"

clean:
	rm -rf $(OBJDIR)
